//--- common/riscv_em_cfg.svh
`ifndef RISCV_EM_CFG_SVH
`define RISCV_EM_CFG_SVH

// ##################################################
// e/m stage configuration
// ##################################################

// data, address and immediate width
`define RISCV_EM_XLEN 64

// data memory size in doublewords
`define RISCV_EM_DMEM_DEPTH 512

`endif

//--- common/riscv_em_pkg.sv
`include "riscv_em_cfg.svh"

package riscv_em_pkg;

    typedef logic [`RISCV_EM_XLEN-1:0] xlen_t;
    typedef logic [4:0]                regaddr_t;
    typedef logic [6:0]                opcode_t;
    typedef logic [31:0]               inst_t;
    typedef logic [15:0]               cinst_t;
    typedef logic [7:0]                strb_t;

    // writeback value select
    typedef enum logic [1:0] {
        rs_alu  = 2'b00,
        rs_load = 2'b01,
        rs_pc4  = 2'b10,
        rs_imm  = 2'b11
    } resultsrc_e;

    // store access size
    typedef enum logic [1:0] {
        st_byte   = 2'b00,
        st_half   = 2'b01,
        st_word   = 2'b10,
        st_double = 2'b11
    } storesrc_e;

    // load kind, same coding as funct3
    typedef enum logic [2:0] {
        mx_lb  = 3'b000,
        mx_lh  = 3'b001,
        mx_lw  = 3'b010,
        mx_ld  = 3'b011,
        mx_lbu = 3'b100,
        mx_lhu = 3'b101,
        mx_lwu = 3'b110
    } memext_e;

    // one doubleword seen as bytes, halves or words
    typedef union packed {
        logic [7:0][7:0]           b;
        logic [3:0][15:0]          h;
        logic [1:0][31:0]          w;
        logic [`RISCV_EM_XLEN-1:0] dw;
    } dword_u;

endpackage

//--- hdl/riscv_em_ppreg.sv
module riscv_em_ppreg
(
    input  logic                    i_riscv_em_clk,
    input  logic                    i_riscv_em_rst,
    input  logic                    i_riscv_em_stall,
    input  logic                    i_riscv_em_memw_e,
    input  logic                    i_riscv_em_regw_e,
    input  riscv_em_pkg::resultsrc_e i_riscv_em_resultsrc_e,
    input  riscv_em_pkg::storesrc_e  i_riscv_em_storesrc_e,
    input  riscv_em_pkg::memext_e    i_riscv_em_memext_e,
    input  riscv_em_pkg::xlen_t      i_riscv_em_pcplus4_e,
    input  riscv_em_pkg::xlen_t      i_riscv_em_result_e,
    input  riscv_em_pkg::xlen_t      i_riscv_em_storedata_e,
    input  riscv_em_pkg::xlen_t      i_riscv_em_imm_e,
    input  riscv_em_pkg::regaddr_t   i_riscv_em_rdaddr_e,
    input  riscv_em_pkg::opcode_t    i_riscv_em_opcode_e,
    input  riscv_em_pkg::inst_t      i_riscv_em_inst_e,
    input  riscv_em_pkg::cinst_t     i_riscv_em_cinst_e,
    output logic                    o_riscv_em_memw_m,
    output logic                    o_riscv_em_regw_m,
    output riscv_em_pkg::resultsrc_e o_riscv_em_resultsrc_m,
    output riscv_em_pkg::storesrc_e  o_riscv_em_storesrc_m,
    output riscv_em_pkg::memext_e    o_riscv_em_memext_m,
    output riscv_em_pkg::xlen_t      o_riscv_em_pcplus4_m,
    output riscv_em_pkg::xlen_t      o_riscv_em_result_m,
    output riscv_em_pkg::xlen_t      o_riscv_em_storedata_m,
    output riscv_em_pkg::xlen_t      o_riscv_em_imm_m,
    output riscv_em_pkg::regaddr_t   o_riscv_em_rdaddr_m,
    output riscv_em_pkg::opcode_t    o_riscv_em_opcode_m,
    output riscv_em_pkg::inst_t      o_riscv_em_inst_m,
    output riscv_em_pkg::cinst_t     o_riscv_em_cinst_m
);

    import riscv_em_pkg::*;

    // ##################################################
    // execute to memory register
    // ##################################################

    always_ff @(posedge i_riscv_em_clk or posedge i_riscv_em_rst)
    begin
        if (i_riscv_em_rst)
        begin
            o_riscv_em_memw_m      <= 1'b0;
            o_riscv_em_regw_m      <= 1'b0;
            o_riscv_em_resultsrc_m <= rs_alu;
            o_riscv_em_storesrc_m  <= st_byte;
            o_riscv_em_memext_m    <= mx_lb;
            o_riscv_em_pcplus4_m   <= '0;
            o_riscv_em_result_m    <= '0;
            o_riscv_em_storedata_m <= '0;
            o_riscv_em_imm_m       <= '0;
            o_riscv_em_rdaddr_m    <= '0;
            o_riscv_em_opcode_m    <= '0;
            o_riscv_em_inst_m      <= '0;
            o_riscv_em_cinst_m     <= '0;
        end
        else if (!i_riscv_em_stall)
        begin
            // control levels
            o_riscv_em_memw_m      <= i_riscv_em_memw_e;
            o_riscv_em_regw_m      <= i_riscv_em_regw_e;
            o_riscv_em_resultsrc_m <= i_riscv_em_resultsrc_e;
            o_riscv_em_storesrc_m  <= i_riscv_em_storesrc_e;
            o_riscv_em_memext_m    <= i_riscv_em_memext_e;

            // data path
            o_riscv_em_pcplus4_m   <= i_riscv_em_pcplus4_e;
            o_riscv_em_result_m    <= i_riscv_em_result_e;
            o_riscv_em_storedata_m <= i_riscv_em_storedata_e;
            o_riscv_em_imm_m       <= i_riscv_em_imm_e;
            o_riscv_em_rdaddr_m    <= i_riscv_em_rdaddr_e;

            // passed on for hazard and trace logic
            o_riscv_em_opcode_m    <= i_riscv_em_opcode_e;
            o_riscv_em_inst_m      <= i_riscv_em_inst_e;
            o_riscv_em_cinst_m     <= i_riscv_em_cinst_e;
        end
    end

endmodule

//--- mstage/riscv_em_storefmt.sv
module riscv_em_storefmt
(
    input  riscv_em_pkg::xlen_t     i_riscv_em_addr_m,
    input  riscv_em_pkg::xlen_t     i_riscv_em_storedata_m,
    input  riscv_em_pkg::storesrc_e i_riscv_em_storesrc_m,
    input  logic                   i_riscv_em_memw_m,
    output riscv_em_pkg::dword_u    o_riscv_em_wdata,
    output riscv_em_pkg::strb_t     o_riscv_em_wstrb
);

    import riscv_em_pkg::*;

    strb_t lane_strb;

    // ##################################################
    // lane replication and strobe select
    // ##################################################

    always_comb
    begin
        case (i_riscv_em_storesrc_m)
            st_byte:
            begin
                o_riscv_em_wdata.b = {8{i_riscv_em_storedata_m[7:0]}};
                lane_strb          = 8'h01 << i_riscv_em_addr_m[2:0];
            end
            st_half:
            begin
                // low address bit ignored, half is forced aligned
                o_riscv_em_wdata.h = {4{i_riscv_em_storedata_m[15:0]}};
                lane_strb          = 8'h03 << {i_riscv_em_addr_m[2:1], 1'b0};
            end
            st_word:
            begin
                o_riscv_em_wdata.w = {2{i_riscv_em_storedata_m[31:0]}};
                lane_strb          = 8'h0f << {i_riscv_em_addr_m[2], 2'b00};
            end
            default:
            begin
                o_riscv_em_wdata.dw = i_riscv_em_storedata_m;
                lane_strb           = 8'hff;
            end
        endcase
    end

    // no write unless the m stage holds a store
    assign o_riscv_em_wstrb = i_riscv_em_memw_m ? lane_strb : 8'h00;

endmodule

//--- mstage/riscv_em_dmem.sv
`include "riscv_em_cfg.svh"

module riscv_em_dmem
#(
    parameter int DEPTH = `RISCV_EM_DMEM_DEPTH
)
(
    input  logic                 i_riscv_em_clk,
    input  riscv_em_pkg::xlen_t  i_riscv_em_addr_m,
    input  riscv_em_pkg::dword_u i_riscv_em_wdata,
    input  riscv_em_pkg::strb_t  i_riscv_em_wstrb,
    output riscv_em_pkg::dword_u o_riscv_em_rdata
);

    import riscv_em_pkg::*;

    localparam int IDXW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

    dword_u            mem [DEPTH];
    logic [IDXW-1:0]   idx;

    // doubleword index, wraps at the memory size
    assign idx = IDXW'((i_riscv_em_addr_m >> 3) % DEPTH);

    // ##################################################
    // byte strobed write
    // ##################################################

    always_ff @(posedge i_riscv_em_clk)
    begin
        for (int i = 0; i < 8; i++)
        begin
            if (i_riscv_em_wstrb[i])
            begin
                mem[idx].b[i] <= i_riscv_em_wdata.b[i];
            end
        end
    end

    // asynchronous read
    assign o_riscv_em_rdata = mem[idx];

endmodule

//--- mstage/riscv_em_mresult.sv
`include "riscv_em_cfg.svh"

module riscv_em_mresult
(
    input  riscv_em_pkg::dword_u     i_riscv_em_rdata,
    input  riscv_em_pkg::xlen_t      i_riscv_em_addr_m,
    input  riscv_em_pkg::xlen_t      i_riscv_em_pcplus4_m,
    input  riscv_em_pkg::xlen_t      i_riscv_em_imm_m,
    input  riscv_em_pkg::memext_e    i_riscv_em_memext_m,
    input  riscv_em_pkg::resultsrc_e i_riscv_em_resultsrc_m,
    output riscv_em_pkg::xlen_t      o_riscv_em_wbdata_m
);

    import riscv_em_pkg::*;

    logic [7:0]  byte_lane;
    logic [15:0] half_lane;
    logic [31:0] word_lane;
    xlen_t       load_data;

    // ##################################################
    // lane extraction
    // ##################################################

    assign byte_lane = i_riscv_em_rdata.b[i_riscv_em_addr_m[2:0]];
    assign half_lane = i_riscv_em_rdata.h[i_riscv_em_addr_m[2:1]];
    assign word_lane = i_riscv_em_rdata.w[i_riscv_em_addr_m[2]];

    // sign or zero extension by load kind
    always_comb
    begin
        case (i_riscv_em_memext_m)
            mx_lb:   load_data = {{(`RISCV_EM_XLEN-8){byte_lane[7]}}, byte_lane};
            mx_lh:   load_data = {{(`RISCV_EM_XLEN-16){half_lane[15]}}, half_lane};
            mx_lw:   load_data = {{(`RISCV_EM_XLEN-32){word_lane[31]}}, word_lane};
            mx_ld:   load_data = i_riscv_em_rdata.dw;
            mx_lbu:  load_data = {{(`RISCV_EM_XLEN-8){1'b0}}, byte_lane};
            mx_lhu:  load_data = {{(`RISCV_EM_XLEN-16){1'b0}}, half_lane};
            mx_lwu:  load_data = {{(`RISCV_EM_XLEN-32){1'b0}}, word_lane};
            default: load_data = '0;
        endcase
    end

    // ##################################################
    // writeback select
    // ##################################################

    always_comb
    begin
        case (i_riscv_em_resultsrc_m)
            rs_alu:  o_riscv_em_wbdata_m = i_riscv_em_addr_m;
            rs_load: o_riscv_em_wbdata_m = load_data;
            rs_pc4:  o_riscv_em_wbdata_m = i_riscv_em_pcplus4_m;
            default: o_riscv_em_wbdata_m = i_riscv_em_imm_m;
        endcase
    end

endmodule

//--- hdl/riscv_em_top.sv
module riscv_em_top
(
    input  logic                    i_riscv_em_clk,
    input  logic                    i_riscv_em_rst,
    input  logic                    i_riscv_em_stall,
    input  logic                    i_riscv_em_memw_e,
    input  logic                    i_riscv_em_regw_e,
    input  riscv_em_pkg::resultsrc_e i_riscv_em_resultsrc_e,
    input  riscv_em_pkg::storesrc_e  i_riscv_em_storesrc_e,
    input  riscv_em_pkg::memext_e    i_riscv_em_memext_e,
    input  riscv_em_pkg::xlen_t      i_riscv_em_pcplus4_e,
    input  riscv_em_pkg::xlen_t      i_riscv_em_result_e,
    input  riscv_em_pkg::xlen_t      i_riscv_em_storedata_e,
    input  riscv_em_pkg::xlen_t      i_riscv_em_imm_e,
    input  riscv_em_pkg::regaddr_t   i_riscv_em_rdaddr_e,
    input  riscv_em_pkg::opcode_t    i_riscv_em_opcode_e,
    input  riscv_em_pkg::inst_t      i_riscv_em_inst_e,
    input  riscv_em_pkg::cinst_t     i_riscv_em_cinst_e,
    output riscv_em_pkg::xlen_t      o_riscv_em_wbdata_m,
    output logic                    o_riscv_em_regw_m,
    output riscv_em_pkg::regaddr_t   o_riscv_em_rdaddr_m,
    output logic                    o_riscv_em_memw_m,
    output riscv_em_pkg::opcode_t    o_riscv_em_opcode_m,
    output riscv_em_pkg::inst_t      o_riscv_em_inst_m,
    output riscv_em_pkg::cinst_t     o_riscv_em_cinst_m,
    output riscv_em_pkg::xlen_t      o_riscv_em_result_m
);

    import riscv_em_pkg::*;

    resultsrc_e resultsrc_m;
    storesrc_e  storesrc_m;
    memext_e    memext_m;
    xlen_t      pcplus4_m;
    xlen_t      storedata_m;
    xlen_t      imm_m;
    dword_u     wdata;
    strb_t      wstrb;
    dword_u     rdata;

    // ##################################################
    // e/m register
    // ##################################################

    riscv_em_ppreg u_ppreg (
        .i_riscv_em_clk         (i_riscv_em_clk),
        .i_riscv_em_rst         (i_riscv_em_rst),
        .i_riscv_em_stall       (i_riscv_em_stall),
        .i_riscv_em_memw_e      (i_riscv_em_memw_e),
        .i_riscv_em_regw_e      (i_riscv_em_regw_e),
        .i_riscv_em_resultsrc_e (i_riscv_em_resultsrc_e),
        .i_riscv_em_storesrc_e  (i_riscv_em_storesrc_e),
        .i_riscv_em_memext_e    (i_riscv_em_memext_e),
        .i_riscv_em_pcplus4_e   (i_riscv_em_pcplus4_e),
        .i_riscv_em_result_e    (i_riscv_em_result_e),
        .i_riscv_em_storedata_e (i_riscv_em_storedata_e),
        .i_riscv_em_imm_e       (i_riscv_em_imm_e),
        .i_riscv_em_rdaddr_e    (i_riscv_em_rdaddr_e),
        .i_riscv_em_opcode_e    (i_riscv_em_opcode_e),
        .i_riscv_em_inst_e      (i_riscv_em_inst_e),
        .i_riscv_em_cinst_e     (i_riscv_em_cinst_e),
        .o_riscv_em_memw_m      (o_riscv_em_memw_m),
        .o_riscv_em_regw_m      (o_riscv_em_regw_m),
        .o_riscv_em_resultsrc_m (resultsrc_m),
        .o_riscv_em_storesrc_m  (storesrc_m),
        .o_riscv_em_memext_m    (memext_m),
        .o_riscv_em_pcplus4_m   (pcplus4_m),
        .o_riscv_em_result_m    (o_riscv_em_result_m),
        .o_riscv_em_storedata_m (storedata_m),
        .o_riscv_em_imm_m       (imm_m),
        .o_riscv_em_rdaddr_m    (o_riscv_em_rdaddr_m),
        .o_riscv_em_opcode_m    (o_riscv_em_opcode_m),
        .o_riscv_em_inst_m      (o_riscv_em_inst_m),
        .o_riscv_em_cinst_m     (o_riscv_em_cinst_m)
    );

    // ##################################################
    // memory stage
    // ##################################################

    // alu result is the memory address
    riscv_em_storefmt u_storefmt (
        .i_riscv_em_addr_m      (o_riscv_em_result_m),
        .i_riscv_em_storedata_m (storedata_m),
        .i_riscv_em_storesrc_m  (storesrc_m),
        .i_riscv_em_memw_m      (o_riscv_em_memw_m),
        .o_riscv_em_wdata       (wdata),
        .o_riscv_em_wstrb       (wstrb)
    );

    riscv_em_dmem u_dmem (
        .i_riscv_em_clk         (i_riscv_em_clk),
        .i_riscv_em_addr_m      (o_riscv_em_result_m),
        .i_riscv_em_wdata       (wdata),
        .i_riscv_em_wstrb       (wstrb),
        .o_riscv_em_rdata       (rdata)
    );

    riscv_em_mresult u_mresult (
        .i_riscv_em_rdata       (rdata),
        .i_riscv_em_addr_m      (o_riscv_em_result_m),
        .i_riscv_em_pcplus4_m   (pcplus4_m),
        .i_riscv_em_imm_m       (imm_m),
        .i_riscv_em_memext_m    (memext_m),
        .i_riscv_em_resultsrc_m (resultsrc_m),
        .o_riscv_em_wbdata_m    (o_riscv_em_wbdata_m)
    );

endmodule

//--- testbench/riscv_em_tb_tasks.svh
`ifndef RISCV_EM_TB_TASKS_SVH
`define RISCV_EM_TB_TASKS_SVH

// ##################################################
// compare tasks
// ##################################################

task automatic record_check(input logic ok, input string name, input string exp_s,
                            input string act_s);
    check_count++;
    if (!ok)
    begin
        error_count++;
        $display("[FAIL] %0t %s: expected %s, actual %s", $time, name, exp_s, act_s);
    end
endtask

task automatic check_dword(input string name, input xlen_t exp, input xlen_t act);
    record_check(act === exp, name, $sformatf("%h", exp), $sformatf("%h", act));
endtask

task automatic check_regaddr(input string name, input regaddr_t exp, input regaddr_t act);
    record_check(act === exp, name, $sformatf("%h", exp), $sformatf("%h", act));
endtask

task automatic check_inst(input string name, input inst_t exp, input inst_t act);
    record_check(act === exp, name, $sformatf("%h", exp), $sformatf("%h", act));
endtask

task automatic check_cinst(input string name, input cinst_t exp, input cinst_t act);
    record_check(act === exp, name, $sformatf("%h", exp), $sformatf("%h", act));
endtask

task automatic check_opcode(input string name, input opcode_t exp, input opcode_t act);
    record_check(act === exp, name, $sformatf("%h", exp), $sformatf("%h", act));
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
    record_check(act === exp, name, $sformatf("%b", exp), $sformatf("%b", act));
endtask

task automatic check_passthru();
    check_dword("wbdata_m", exp_wb, wbdata_m);
    check_dword("result_m", exp_res, result_m);
    check_regaddr("rdaddr_m", exp_rd, rdaddr_m);
    check_bit("regw_m", exp_regw, regw_m);
    check_bit("memw_m", exp_memw, memw_m);
    check_opcode("opcode_m", exp_op, opcode_m);
    check_inst("inst_m", exp_inst, inst_m);
    check_cinst("cinst_m", exp_cinst, cinst_m);
endtask

// ##################################################
// drive helpers
// ##################################################

task automatic wait_falls(input int cycles);
    int  n;
    time limit;
    n     = 0;
    limit = $time + time'((cycles + 1) * CLK_PERIOD);
    while (n < cycles && $time <= limit)
    begin
        @(negedge clk);
        n++;
    end
    if (n < cycles || $time > limit)
    begin
        $display("timeout: falling clock edges did not arrive in time");
        error_count++;
        finish_run();
    end
endtask

function automatic xlen_t rand_dword();
    return {$random(seed), $random(seed)};
endfunction

task automatic set_idle();
    memw      = 1'b0;
    regw      = 1'b0;
    resultsrc = rs_alu;
    storesrc  = st_byte;
    memext    = mx_lb;
    pcplus4   = '0;
    result    = '0;
    storedata = '0;
    imm       = '0;
    rdaddr    = '0;
    opcode    = '0;
    inst      = '0;
    cinst     = '0;
endtask

task automatic drive_random_op(input resultsrc_e sel);
    memw      = 1'b0;
    regw      = 1'b1;
    resultsrc = sel;
    pcplus4   = rand_dword();
    result    = rand_dword();
    storedata = rand_dword();
    imm       = rand_dword();
    rdaddr    = regaddr_t'($random(seed));
    opcode    = opcode_t'($random(seed));
    inst      = $random(seed);
    cinst     = cinst_t'($random(seed));
endtask

// writeback select rule for the non-load sources
task automatic capture_expected();
    case (resultsrc)
        rs_pc4:  exp_wb = pcplus4;
        rs_imm:  exp_wb = imm;
        default: exp_wb = result;
    endcase
    exp_res   = result;
    exp_rd    = rdaddr;
    exp_regw  = regw;
    exp_memw  = memw;
    exp_op    = opcode;
    exp_inst  = inst;
    exp_cinst = cinst;
endtask

task automatic do_store(input xlen_t addr, input xlen_t data, input storesrc_e sz);
    set_idle();
    memw      = 1'b1;
    result    = addr;
    storedata = data;
    storesrc  = sz;
    ref_store(addr, data, sz);
    wait_falls(1);
    check_bit("memw_m", 1'b1, memw_m);
    check_bit("regw_m", 1'b0, regw_m);
endtask

task automatic do_load(input xlen_t addr, input memext_e kind);
    regaddr_t rd;
    set_idle();
    rd        = regaddr_t'($random(seed));
    regw      = 1'b1;
    resultsrc = rs_load;
    memext    = kind;
    result    = addr;
    rdaddr    = rd;
    wait_falls(1);
    check_dword("wbdata_m", expected_load(addr, kind), wbdata_m);
    check_regaddr("rdaddr_m", rd, rdaddr_m);
endtask

// ##################################################
// directed tests
// ##################################################

task automatic reset_test();
    drive_random_op(rs_imm);
    memw = 1'b1;
    wait_falls(RST_CYCLES);
    check_bit("memw_m", 1'b0, memw_m);
    check_bit("regw_m", 1'b0, regw_m);
    check_dword("wbdata_m", '0, wbdata_m);
    check_regaddr("rdaddr_m", '0, rdaddr_m);
    rst = 1'b0;
    set_idle();
    // released, no edge sampled yet
    check_bit("memw_m", 1'b0, memw_m);
    check_bit("regw_m", 1'b0, regw_m);
    check_dword("wbdata_m", '0, wbdata_m);
    check_regaddr("rdaddr_m", '0, rdaddr_m);
endtask

task automatic passthru_test();
    for (int n = 0; n < 2; n++)
    begin
        for (int s = 0; s < 4; s++)
        begin
            if (resultsrc_e'(s) != rs_load)
            begin
                drive_random_op(resultsrc_e'(s));
                capture_expected();
                wait_falls(1);
                check_passthru();
            end
        end
    end
endtask

task automatic stall_test();
    drive_random_op(rs_alu);
    capture_expected();
    wait_falls(1);
    check_passthru();
    stall = 1'b1;
    for (int i = 0; i < 4; i++)
    begin
        drive_random_op(i[0] ? rs_imm : rs_pc4);
        // control levels differ from the held ones on even cycles
        regw = i[0];
        memw = ~i[0];
        wait_falls(1);
        check_passthru();
    end
    // last driven values enter on the first free edge
    stall = 1'b0;
    capture_expected();
    wait_falls(1);
    check_passthru();
endtask

task automatic store_load_test();
    xlen_t base;
    int    nb;
    for (int s = 0; s < 4; s++)
    begin
        for (int n = 0; n < 2; n++)
        begin
            base = rand_dword() & ~64'h7;
            do_store(base, rand_dword(), st_double);
            do_store(base | xlen_t'($random(seed) & 7), rand_dword(), storesrc_e'(s));
            for (int k = 0; k < 7; k++)
            begin
                nb = 1 << (k % 4);
                for (int off = 0; off < 8; off += nb)
                begin
                    do_load(base + xlen_t'(off), memext_e'(k));
                end
            end
        end
    end
endtask

task automatic partial_store_test();
    xlen_t base;
    xlen_t fill;
    base = rand_dword() & ~64'h7;
    fill = rand_dword();
    do_store(base, fill, st_double);
    do_store(base + 64'd3, rand_dword(), st_byte);
    do_load(base, mx_ld);
    // store shaped operation with memory write low
    set_idle();
    result    = base;
    storedata = ~fill;
    storesrc  = st_double;
    wait_falls(2);
    do_load(base, mx_ld);
endtask

task automatic back_to_back_test();
    xlen_t addr;
    xlen_t data;
    xlen_t mask;
    for (int s = 0; s < 4; s++)
    begin
        addr = rand_dword();
        data = rand_dword();
        mask = '1;
        if (s < 3)
        begin
            mask = (xlen_t'(1) << (8 << s)) - 1;
        end
        do_store(addr, data, storesrc_e'(s));
        do_load(addr, memext_e'((s == 3) ? 3 : s + 4));
        check_dword("wbdata_m", data & mask, wbdata_m);
    end
endtask

`endif

//--- testbench/riscv_em_tb.sv
`include "riscv_em_cfg.svh"

module riscv_em_tb;

    import riscv_em_pkg::*;

    localparam int CLK_PERIOD = 10;
    localparam int RST_CYCLES = 16;
    localparam int MEM_BYTES  = `RISCV_EM_DMEM_DEPTH * 8;

    logic       clk;
    logic       rst;
    logic       stall;
    logic       memw;
    logic       regw;
    resultsrc_e resultsrc;
    storesrc_e  storesrc;
    memext_e    memext;
    xlen_t      pcplus4;
    xlen_t      result;
    xlen_t      storedata;
    xlen_t      imm;
    regaddr_t   rdaddr;
    opcode_t    opcode;
    inst_t      inst;
    cinst_t     cinst;

    xlen_t      wbdata_m;
    logic       regw_m;
    regaddr_t   rdaddr_m;
    logic       memw_m;
    opcode_t    opcode_m;
    inst_t      inst_m;
    cinst_t     cinst_m;
    xlen_t      result_m;

    // expected m stage values for non-load operations
    xlen_t      exp_wb;
    xlen_t      exp_res;
    regaddr_t   exp_rd;
    logic       exp_regw;
    logic       exp_memw;
    opcode_t    exp_op;
    inst_t      exp_inst;
    cinst_t     exp_cinst;

    logic [7:0] ref_mem [MEM_BYTES];
    int         seed = 32'hcd29_d6ed;
    int         error_count;
    int         check_count;

    riscv_em_top dut0 (
        .i_riscv_em_clk         (clk),
        .i_riscv_em_rst         (rst),
        .i_riscv_em_stall       (stall),
        .i_riscv_em_memw_e      (memw),
        .i_riscv_em_regw_e      (regw),
        .i_riscv_em_resultsrc_e (resultsrc),
        .i_riscv_em_storesrc_e  (storesrc),
        .i_riscv_em_memext_e    (memext),
        .i_riscv_em_pcplus4_e   (pcplus4),
        .i_riscv_em_result_e    (result),
        .i_riscv_em_storedata_e (storedata),
        .i_riscv_em_imm_e       (imm),
        .i_riscv_em_rdaddr_e    (rdaddr),
        .i_riscv_em_opcode_e    (opcode),
        .i_riscv_em_inst_e      (inst),
        .i_riscv_em_cinst_e     (cinst),
        .o_riscv_em_wbdata_m    (wbdata_m),
        .o_riscv_em_regw_m      (regw_m),
        .o_riscv_em_rdaddr_m    (rdaddr_m),
        .o_riscv_em_memw_m      (memw_m),
        .o_riscv_em_opcode_m    (opcode_m),
        .o_riscv_em_inst_m      (inst_m),
        .o_riscv_em_cinst_m     (cinst_m),
        .o_riscv_em_result_m    (result_m)
    );

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    // ##################################################
    // reference memory model
    // ##################################################

    // first byte of the doubleword an address selects
    function automatic int ref_base(input xlen_t addr);
        return int'((addr >> 3) % `RISCV_EM_DMEM_DEPTH) * 8;
    endfunction

    // low bytes of the data land in the naturally aligned lane
    function automatic void ref_store(input xlen_t addr, input xlen_t data, input storesrc_e sz);
        int nb;
        int pos;
        nb  = 1 << int'(sz);
        pos = ref_base(addr) + (int'(addr[2:0]) & ~(nb - 1));
        for (int i = 0; i < nb; i++)
        begin
            ref_mem[pos + i] = data[8*i +: 8];
        end
    endfunction

    function automatic xlen_t expected_load(input xlen_t addr, input memext_e kind);
        int    nb;
        int    pos;
        xlen_t val;
        nb  = 1 << int'(kind[1:0]);
        pos = ref_base(addr) + (int'(addr[2:0]) & ~(nb - 1));
        val = '0;
        for (int i = 0; i < nb; i++)
        begin
            val[8*i +: 8] = ref_mem[pos + i];
        end
        // funct3 bit 2 clear means a signed load
        if (!kind[2] && val[8*nb-1])
        begin
            for (int i = 8 * nb; i < `RISCV_EM_XLEN; i++)
            begin
                val[i] = 1'b1;
            end
        end
        return val;
    endfunction

    task automatic finish_run();
        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0)
        begin
            $display("test passed");
        end
        else
        begin
            $display("test failed");
        end
        $finish;
    endtask

    `include "riscv_em_tb_tasks.svh"

    initial
    begin
        error_count = 0;
        check_count = 0;
        rst         = 1'b1;
        stall       = 1'b0;
        set_idle();
        reset_test();
        passthru_test();
        stall_test();
        store_load_test();
        partial_store_test();
        back_to_back_test();
        finish_run();
    end

endmodule

//--- riscv_em.f
+incdir+common
+incdir+testbench
common/riscv_em_pkg.sv
hdl/riscv_em_ppreg.sv
mstage/riscv_em_storefmt.sv
mstage/riscv_em_dmem.sv
mstage/riscv_em_mresult.sv
hdl/riscv_em_top.sv
testbench/riscv_em_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= riscv_em_tb
RTL_TOP   ?= riscv_em_top
FILELIST  ?= riscv_em.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0
LINTFLAGS ?= --lint-only
RTL_SRCS  ?= common/riscv_em_pkg.sv hdl/riscv_em_ppreg.sv mstage/riscv_em_storefmt.sv \
             mstage/riscv_em_dmem.sv mstage/riscv_em_mresult.sv hdl/riscv_em_top.sv
HEADERS   ?= common/riscv_em_cfg.svh testbench/riscv_em_tb_tasks.svh

.PHONY: all build run lint clean

all: run

build: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(RTL_SRCS) testbench/riscv_em_tb.sv $(HEADERS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qx "test passed" $(LOG); then \
		echo "simulation result: pass"; \
	else \
		echo "simulation result: fail, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINTFLAGS) +incdir+common --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
